// File: verilog/axi_sram_pkg.sv
package axi_sram_pkg;

    // Beats minus one, as carried on AWLEN and ARLEN
    typedef logic [7:0] axi_len_t;

    typedef logic [1:0] axi_resp_t;

    localparam axi_resp_t RESP_OKAY = 2'b00;

    // Write engine
    typedef enum logic [1:0] {
        WR_IDLE, // Waiting on AW
        WR_DATA, // Taking W beats
        WR_RESP  // Holding B until accepted
    } wr_state_e;

    // Read engine
    typedef enum logic {
        RD_IDLE,
        RD_BURST // Issuing memory reads
    } rd_state_e;

endpackage

// File: verilog/axi4_if.sv
`timescale 1ns/1ps

interface axi4_if #(
    parameter int AXI_ADDR_WIDTH = 32,
    parameter int AXI_DATA_WIDTH = 32,
    parameter int AXI_ID_WIDTH   = 4
);
    import axi_sram_pkg::*;

    // Write address
    logic [AXI_ID_WIDTH-1:0]     AWID;
    logic [AXI_ADDR_WIDTH-1:0]   AWADDR;
    axi_len_t                    AWLEN;
    logic                        AWVALID;
    logic                        AWREADY;

    // Write data
    logic [AXI_DATA_WIDTH-1:0]   WDATA;
    logic [AXI_DATA_WIDTH/8-1:0] WSTRB;
    logic                        WLAST;
    logic                        WVALID;
    logic                        WREADY;

    // Write response
    logic [AXI_ID_WIDTH-1:0]     BID;
    axi_resp_t                   BRESP;
    logic                        BVALID;
    logic                        BREADY;

    // Read address
    logic [AXI_ID_WIDTH-1:0]     ARID;
    logic [AXI_ADDR_WIDTH-1:0]   ARADDR;
    axi_len_t                    ARLEN;
    logic                        ARVALID;
    logic                        ARREADY;

    // Read data
    logic [AXI_ID_WIDTH-1:0]     RID;
    logic [AXI_DATA_WIDTH-1:0]   RDATA;
    axi_resp_t                   RRESP;
    logic                        RLAST;
    logic                        RVALID;
    logic                        RREADY;

    // Address and write channels, B response
    modport engine (
        input  AWID, AWADDR, AWLEN, AWVALID,
        output AWREADY,
        input  WDATA, WSTRB, WLAST, WVALID,
        output WREADY,
        output BID, BRESP, BVALID,
        input  BREADY,
        input  ARID, ARADDR, ARLEN, ARVALID,
        output ARREADY
    );

    // R channel source
    modport r_out (
        output RID, RDATA, RRESP, RLAST, RVALID,
        input  RREADY
    );

    // Seen from the external master side
    modport ext (
        output AWID, AWADDR, AWLEN, AWVALID, WDATA, WSTRB, WLAST, WVALID,
        output BREADY, ARID, ARADDR, ARLEN, ARVALID, RREADY,
        input  AWREADY, WREADY, BID, BRESP, BVALID, ARREADY,
        input  RID, RDATA, RRESP, RLAST, RVALID
    );

endinterface

// File: verilog/sram_port_if.sv
`timescale 1ns/1ps

// Single shared memory port
interface sram_port_if #(
    parameter int MEM_ADDR_BITS  = 10,
    parameter int AXI_DATA_WIDTH = 32
);
    logic [MEM_ADDR_BITS-1:0]    addr;
    logic                        we;
    logic                        re;
    logic [AXI_DATA_WIDTH-1:0]   wdata;
    logic [AXI_DATA_WIDTH/8-1:0] wstrb; // One bit per byte lane
    logic [AXI_DATA_WIDTH-1:0]   rdata; // Valid the cycle after re

    modport ctrl (
        output addr, we, re, wdata, wstrb,
        input  rdata
    );

    modport mem (
        input  addr, we, re, wdata, wstrb,
        output rdata
    );

endinterface

// Read beats from the engine to the R buffer
interface r_beat_if #(
    parameter int AXI_DATA_WIDTH = 32,
    parameter int AXI_ID_WIDTH   = 4
);
    logic                      issue; // Memory read started this cycle
    logic [AXI_ID_WIDTH-1:0]   id;
    logic                      last;
    logic [AXI_DATA_WIDTH-1:0] rdata;
    logic                      room;  // Buffer can take another beat

    modport src (
        output issue, id, last, rdata,
        input  room
    );

    modport sink (
        input  issue, id, last, rdata,
        output room
    );

endinterface

// File: verilog/axi4_sram.sv
`timescale 1ns/1ps

module axi4_sram #(
    parameter int MEM_ADDR_BITS  = 10,
    parameter int AXI_ADDR_WIDTH = 32,
    parameter int AXI_DATA_WIDTH = 32,
    parameter int AXI_ID_WIDTH   = 4
) (
    input logic       ACLK,
    input logic       ARESETn,
    axi4_if.engine    s,
    sram_port_if.ctrl mem,
    r_beat_if.src     rb
);
    import axi_sram_pkg::*;

    localparam int BYTE_BITS = $clog2(AXI_DATA_WIDTH / 8); // Byte offset within a word

    // Port owner encoding
    localparam logic [1:0] OWN_NONE = 2'd0;
    localparam logic [1:0] OWN_WR   = 2'd1;
    localparam logic [1:0] OWN_RD   = 2'd2;

    typedef logic [MEM_ADDR_BITS-1:0] word_addr_t;
    typedef logic [AXI_ID_WIDTH-1:0]  id_t;

    wr_state_e  wr_state;
    rd_state_e  rd_state;
    logic [1:0] owner;

    word_addr_t wr_addr;
    axi_len_t   wr_len;
    axi_len_t   wr_cnt;
    id_t        wr_id;

    word_addr_t rd_addr;
    axi_len_t   rd_len;
    axi_len_t   rd_cnt;
    id_t        rd_id;

    logic aw_fire;
    logic w_fire;
    logic b_fire;
    logic ar_fire;
    logic wr_done;
    logic rd_issue;
    logic rd_last;

    word_addr_t wr_word;
    word_addr_t rd_word;

    // Low bits below the word are dropped, high bits wrap onto the array
    function automatic word_addr_t word_of(input logic [AXI_ADDR_WIDTH-1:0] byte_addr);
        return word_addr_t'(byte_addr >> BYTE_BITS);
    endfunction

    assign aw_fire = s.AWVALID && s.AWREADY;
    assign w_fire  = s.WVALID && s.WREADY;
    assign b_fire  = s.BVALID && s.BREADY;
    assign ar_fire = s.ARVALID && s.ARREADY;

    // WLAST normally ends the burst, the length count backs it up
    assign wr_done = s.WLAST || (wr_cnt == wr_len);

    assign rd_last  = (rd_cnt == rd_len);
    assign rd_issue = (rd_state == RD_BURST) && rb.room;

    assign s.AWREADY = (wr_state == WR_IDLE) && (owner != OWN_RD);
    assign s.WREADY  = (wr_state == WR_DATA);
    assign s.BVALID  = (wr_state == WR_RESP);
    assign s.BID     = wr_id;
    assign s.BRESP   = RESP_OKAY;

    // Write wins when both address channels show up together
    assign s.ARREADY = (rd_state == RD_IDLE) && (owner == OWN_NONE) && !s.AWVALID;

    // Write engine
    always_ff @(posedge ACLK) begin
        if (!ARESETn) begin
            wr_state <= WR_IDLE;
            wr_cnt   <= '0;
        end else begin
            case (wr_state)
                WR_IDLE: begin
                    if (aw_fire) begin
                        wr_state <= WR_DATA;
                        wr_cnt   <= '0;
                    end
                end
                WR_DATA: begin
                    if (w_fire) begin
                        wr_cnt <= wr_cnt + 8'd1;
                        if (wr_done) begin
                            wr_state <= WR_RESP;
                        end
                    end
                end
                WR_RESP: begin
                    if (b_fire) begin
                        wr_state <= WR_IDLE;
                    end
                end
                default: wr_state <= WR_IDLE;
            endcase
        end
    end

    // Read engine issues one read per cycle while the buffer has room
    always_ff @(posedge ACLK) begin
        if (!ARESETn) begin
            rd_state <= RD_IDLE;
            rd_cnt   <= '0;
        end else begin
            case (rd_state)
                RD_IDLE: begin
                    if (ar_fire) begin
                        rd_state <= RD_BURST;
                        rd_cnt   <= '0;
                    end
                end
                RD_BURST: begin
                    if (rd_issue) begin
                        rd_cnt <= rd_cnt + 8'd1;
                        if (rd_last) begin
                            rd_state <= RD_IDLE;
                        end
                    end
                end
                default: rd_state <= RD_IDLE;
            endcase
        end
    end

    // Owner is held from address handshake to end of burst
    always_ff @(posedge ACLK) begin
        if (!ARESETn) begin
            owner <= OWN_NONE;
        end else if (aw_fire) begin
            owner <= OWN_WR;
        end else if (ar_fire) begin
            owner <= OWN_RD;
        end else if (b_fire || (rd_issue && rd_last)) begin
            owner <= OWN_NONE; // Released on B or on the last read issue
        end
    end

    // Burst parameters captured on the address handshakes
    always_ff @(posedge ACLK) begin
        if (aw_fire) begin
            wr_addr <= word_of(s.AWADDR);
            wr_len  <= s.AWLEN;
            wr_id   <= s.AWID;
        end
        if (ar_fire) begin
            rd_addr <= word_of(s.ARADDR);
            rd_len  <= s.ARLEN;
            rd_id   <= s.ARID;
        end
    end

    assign wr_word = wr_addr + word_addr_t'(wr_cnt);
    assign rd_word = rd_addr + word_addr_t'(rd_cnt);

    // Shared memory port
    assign mem.addr  = (owner == OWN_RD) ? rd_word : wr_word;
    assign mem.we    = w_fire;
    assign mem.re    = rd_issue;
    assign mem.wdata = s.WDATA;
    assign mem.wstrb = s.WSTRB;

    // Beat tags travel alongside the memory read
    assign rb.issue = rd_issue;
    assign rb.id    = rd_id;
    assign rb.last  = rd_last;
    assign rb.rdata = mem.rdata;

endmodule

// File: verilog/sram_byte_en.sv
`timescale 1ns/1ps

module sram_byte_en #(
    parameter int MEM_ADDR_BITS  = 10,
    parameter int AXI_DATA_WIDTH = 32
) (
    input logic      ACLK,
    sram_port_if.mem p
);
    localparam int NUM_WORDS = 1 << MEM_ADDR_BITS;
    localparam int NUM_BYTES = AXI_DATA_WIDTH / 8;

    logic [AXI_DATA_WIDTH-1:0] mem_q [NUM_WORDS];

    // Byte lanes written only where the strobe is set
    always_ff @(posedge ACLK) begin
        if (p.we) begin
            for (int b = 0; b < NUM_BYTES; b++) begin
                if (p.wstrb[b]) begin
                    mem_q[p.addr][b*8 +: 8] <= p.wdata[b*8 +: 8];
                end
            end
        end
    end

    // Read data register holds its word between reads
    always_ff @(posedge ACLK) begin
        if (p.re) begin
            p.rdata <= mem_q[p.addr];
        end
    end

endmodule

// File: verilog/axi_r_buffer.sv
`timescale 1ns/1ps

module axi_r_buffer #(
    parameter int AXI_DATA_WIDTH = 32,
    parameter int AXI_ID_WIDTH   = 4
) (
    input logic    ACLK,
    input logic    ARESETn,
    r_beat_if.sink rb,
    axi4_if.r_out  r
);
    import axi_sram_pkg::*;

    typedef logic [AXI_DATA_WIDTH-1:0] data_t;
    typedef logic [AXI_ID_WIDTH-1:0]   id_t;

    logic  in_flight;   // Memory read returns this cycle
    id_t   flight_id;
    logic  flight_last;

    data_t buf_data [2];
    id_t   buf_id   [2];
    logic  buf_last [2];

    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] count;
    logic [1:0] held;   // Entries left after this cycle's pop
    logic       push;
    logic       pop;

    assign push = in_flight;
    assign pop  = r.RVALID && r.RREADY;
    assign held = count - {1'b0, pop};

    // A beat leaving on this edge frees its slot for the next issue
    assign rb.room = (held + {1'b0, in_flight}) < 2'd2;

    always_ff @(posedge ACLK) begin
        if (!ARESETn) begin
            in_flight <= 1'b0;
        end else begin
            in_flight <= rb.issue;
        end
    end

    always_ff @(posedge ACLK) begin
        if (rb.issue) begin
            flight_id   <= rb.id;
            flight_last <= rb.last;
        end
    end

    always_ff @(posedge ACLK) begin
        if (push) begin
            buf_data[wr_ptr] <= rb.rdata;
            buf_id[wr_ptr]   <= flight_id;
            buf_last[wr_ptr] <= flight_last;
        end
    end

    always_ff @(posedge ACLK) begin
        if (!ARESETn) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr <= ~wr_ptr;
            end
            if (pop) begin
                rd_ptr <= ~rd_ptr;
            end
            count <= held + {1'b0, push};
        end
    end

    // FIFO head drives the R channel
    assign r.RVALID = (count != 2'd0);
    assign r.RDATA  = buf_data[rd_ptr];
    assign r.RID    = buf_id[rd_ptr];
    assign r.RLAST  = buf_last[rd_ptr];
    assign r.RRESP  = RESP_OKAY;

endmodule

// File: verilog/axi_sram_top.sv
`timescale 1ns/1ps

module axi_sram_top #(
    parameter int MEM_ADDR_BITS  = 10,
    parameter int AXI_ADDR_WIDTH = 32,
    parameter int AXI_DATA_WIDTH = 32,
    parameter int AXI_ID_WIDTH   = 4
) (
    input  logic                        ACLK,
    input  logic                        ARESETn,

    input  logic [AXI_ID_WIDTH-1:0]     AWID,
    input  logic [AXI_ADDR_WIDTH-1:0]   AWADDR,
    input  axi_sram_pkg::axi_len_t      AWLEN,
    input  logic                        AWVALID,
    output logic                        AWREADY,

    input  logic [AXI_DATA_WIDTH-1:0]   WDATA,
    input  logic [AXI_DATA_WIDTH/8-1:0] WSTRB,
    input  logic                        WLAST,
    input  logic                        WVALID,
    output logic                        WREADY,

    output logic [AXI_ID_WIDTH-1:0]     BID,
    output axi_sram_pkg::axi_resp_t     BRESP,
    output logic                        BVALID,
    input  logic                        BREADY,

    input  logic [AXI_ID_WIDTH-1:0]     ARID,
    input  logic [AXI_ADDR_WIDTH-1:0]   ARADDR,
    input  axi_sram_pkg::axi_len_t      ARLEN,
    input  logic                        ARVALID,
    output logic                        ARREADY,

    output logic [AXI_ID_WIDTH-1:0]     RID,
    output logic [AXI_DATA_WIDTH-1:0]   RDATA,
    output axi_sram_pkg::axi_resp_t     RRESP,
    output logic                        RLAST,
    output logic                        RVALID,
    input  logic                        RREADY
);
    axi4_if #(
        .AXI_ADDR_WIDTH (AXI_ADDR_WIDTH),
        .AXI_DATA_WIDTH (AXI_DATA_WIDTH),
        .AXI_ID_WIDTH   (AXI_ID_WIDTH)
    ) axi_bus ();

    sram_port_if #(
        .MEM_ADDR_BITS  (MEM_ADDR_BITS),
        .AXI_DATA_WIDTH (AXI_DATA_WIDTH)
    ) mem_port ();

    r_beat_if #(
        .AXI_DATA_WIDTH (AXI_DATA_WIDTH),
        .AXI_ID_WIDTH   (AXI_ID_WIDTH)
    ) r_beats ();

    // Inbound channel signals
    assign axi_bus.AWID    = AWID;
    assign axi_bus.AWADDR  = AWADDR;
    assign axi_bus.AWLEN   = AWLEN;
    assign axi_bus.AWVALID = AWVALID;
    assign axi_bus.WDATA   = WDATA;
    assign axi_bus.WSTRB   = WSTRB;
    assign axi_bus.WLAST   = WLAST;
    assign axi_bus.WVALID  = WVALID;
    assign axi_bus.BREADY  = BREADY;
    assign axi_bus.ARID    = ARID;
    assign axi_bus.ARADDR  = ARADDR;
    assign axi_bus.ARLEN   = ARLEN;
    assign axi_bus.ARVALID = ARVALID;
    assign axi_bus.RREADY  = RREADY;

    // Outbound channel signals
    assign AWREADY = axi_bus.AWREADY;
    assign WREADY  = axi_bus.WREADY;
    assign BID     = axi_bus.BID;
    assign BRESP   = axi_bus.BRESP;
    assign BVALID  = axi_bus.BVALID;
    assign ARREADY = axi_bus.ARREADY;
    assign RID     = axi_bus.RID;
    assign RDATA   = axi_bus.RDATA;
    assign RRESP   = axi_bus.RRESP;
    assign RLAST   = axi_bus.RLAST;
    assign RVALID  = axi_bus.RVALID;

    axi4_sram #(
        .MEM_ADDR_BITS  (MEM_ADDR_BITS),
        .AXI_ADDR_WIDTH (AXI_ADDR_WIDTH),
        .AXI_DATA_WIDTH (AXI_DATA_WIDTH),
        .AXI_ID_WIDTH   (AXI_ID_WIDTH)
    ) engine_i (
        .ACLK    (ACLK),
        .ARESETn (ARESETn),
        .s       (axi_bus.engine),
        .mem     (mem_port.ctrl),
        .rb      (r_beats.src)
    );

    sram_byte_en #(
        .MEM_ADDR_BITS  (MEM_ADDR_BITS),
        .AXI_DATA_WIDTH (AXI_DATA_WIDTH)
    ) mem_i (
        .ACLK (ACLK),
        .p    (mem_port.mem)
    );

    axi_r_buffer #(
        .AXI_DATA_WIDTH (AXI_DATA_WIDTH),
        .AXI_ID_WIDTH   (AXI_ID_WIDTH)
    ) rbuf_i (
        .ACLK    (ACLK),
        .ARESETn (ARESETn),
        .rb      (r_beats.sink),
        .r       (axi_bus.r_out)
    );

endmodule

// File: testbench/axi_sram_tb_tasks.svh
function automatic logic chan_ready(input int ch);
    case (ch)
        CH_AW:   return AWREADY;
        CH_W:    return WREADY;
        CH_B:    return BVALID;
        default: return ARREADY;
    endcase
endfunction

// Returns at the falling edge before the transfer edge
task automatic await_transfer(input int ch, input string what);
    int n;
    n = 0;
    @(negedge ACLK);
    while (!chan_ready(ch)) begin
        n++;
        if (n > TIMEOUT) abort_run(what);
        @(negedge ACLK);
    end
endtask

task automatic add_beat(input logic [31:0] data, input logic [3:0] strb);
    wq_data.push_back(data);
    wq_strb.push_back(strb);
endtask

// Byte-wise merge where the strobe is set
task automatic model_write(input logic [9:0] word, input logic [31:0] data,
                           input logic [3:0] strb);
    for (int b = 0; b < 4; b++) begin
        if (strb[b]) ref_mem[word][b*8 +: 8] = data[b*8 +: 8];
    end
endtask

task automatic write_burst(input logic [3:0] id, input logic [31:0] addr, input int beats);
    logic [9:0] word;
    word    = addr[11:2]; // Wraps onto the 1K-word array
    AWID    = id;
    AWADDR  = addr;
    AWLEN   = axi_len_t'(beats - 1);
    AWVALID = 1'b1;
    await_transfer(CH_AW, "AW handshake");
    next_cycle();
    AWVALID = 1'b0;
    for (int i = 0; i < beats; i++) begin
        WDATA  = wq_data[i];
        WSTRB  = wq_strb[i];
        WLAST  = (i == beats - 1);
        WVALID = 1'b1;
        await_transfer(CH_W, "W beat accepted");
        next_cycle();
        model_write(word + 10'(i), wq_data[i], wq_strb[i]);
    end
    WVALID = 1'b0;
    WLAST  = 1'b0;
    BREADY = 1'b1;
    await_transfer(CH_B, "B response");
    last_bid    = BID;
    last_bresp  = BRESP;
    last_b_time = $time;
    next_cycle();
    BREADY = 1'b0;
    wq_data.delete();
    wq_strb.delete();
endtask

task automatic read_burst(input logic [3:0] id, input logic [31:0] addr, input int beats,
                          input bit stall);
    int idle;
    rq_data.delete();
    rq_id.delete();
    rq_resp.delete();
    rq_last.delete();
    ARID    = id;
    ARADDR  = addr;
    ARLEN   = axi_len_t'(beats - 1);
    ARVALID = 1'b1;
    await_transfer(CH_AR, "AR handshake");
    last_ar_time = $time;
    next_cycle();
    ARVALID = 1'b0;
    idle = 0;
    while (rq_data.size() < beats) begin
        RREADY = stall ? 1'($urandom_range(1, 0)) : 1'b1;
        @(negedge ACLK);
        if (RVALID && RREADY) begin
            rq_data.push_back(RDATA);
            rq_id.push_back(RID);
            rq_resp.push_back(RRESP);
            rq_last.push_back(RLAST);
            idle = 0;
        end else begin
            idle++;
            if (idle > TIMEOUT) abort_run("R beat");
        end
        next_cycle();
    end
    RREADY = 1'b0;
endtask

// Compares the collected beats against the model, in address order
task automatic check_read(input logic [31:0] addr, input int beats, input logic [3:0] id);
    logic [9:0] word;
    word = addr[11:2];
    for (int i = 0; i < beats; i++) begin
        check_value($sformatf("RDATA beat %0d", i), ref_mem[word + 10'(i)], rq_data[i]);
        check_value($sformatf("RID beat %0d", i), 32'(id), 32'(rq_id[i]));
        check_value($sformatf("RRESP beat %0d", i), 32'(AXI_OKAY), 32'(rq_resp[i]));
        check_value($sformatf("RLAST beat %0d", i), 32'(i == beats - 1), 32'(rq_last[i]));
    end
endtask

task automatic test_reset_state();
    begin_test("reset_state");
    @(negedge ACLK);
    check_value("AWREADY", 32'd1, 32'(AWREADY));
    check_value("ARREADY", 32'd1, 32'(ARREADY));
    check_value("WREADY", 32'd0, 32'(WREADY));
    check_value("BVALID", 32'd0, 32'(BVALID));
    check_value("RVALID", 32'd0, 32'(RVALID));
    next_cycle();
    end_test();
endtask

task automatic test_single_beat();
    begin_test("single_beat");
    add_beat(32'hA5C3_1E07, 4'hF);
    write_burst(4'h1, 32'h40, 1);
    check_value("BRESP", 32'(AXI_OKAY), 32'(last_bresp));
    read_burst(4'h2, 32'h40, 1, 1'b0);
    check_read(32'h40, 1, 4'h2);
    end_test();
endtask

task automatic test_burst_strobes();
    begin_test("burst_strobes");
    for (int i = 0; i < 8; i++) begin
        add_beat(32'h5A00_0000 + 32'(i) * 32'h0001_0203, 4'hF); // Known background
    end
    write_burst(4'h3, 32'h100, 8);
    add_beat(32'hDEAD_BEEF, 4'b0001);
    add_beat(32'h1234_5678, 4'b0110);
    add_beat(32'hCAFE_F00D, 4'b1000);
    add_beat(32'h8BAD_F00D, 4'b1010);
    write_burst(4'h4, 32'h108, 4);
    read_burst(4'h5, 32'h100, 8, 1'b0);
    check_read(32'h100, 8, 4'h5);
    end_test();
endtask

task automatic test_backpressure();
    begin_test("r_backpressure");
    for (int i = 0; i < 16; i++) begin
        add_beat($urandom(), 4'hF);
    end
    write_burst(4'h6, 32'h200, 16);
    read_burst(4'h7, 32'h200, 16, 1'b1);
    check_read(32'h200, 16, 4'h7);
    RREADY = 1'b1;
    repeat (4) begin
        @(negedge ACLK);
        check_true("extra R beat after the burst", !RVALID);
        next_cycle();
    end
    RREADY = 1'b0;
    end_test();
endtask

task automatic test_ids();
    logic [3:0]  awid;
    logic [3:0]  arid;
    logic [31:0] addr;
    begin_test("ids");
    for (int k = 0; k < 4; k++) begin
        awid = 4'($urandom());
        arid = 4'($urandom());
        addr = 32'h300 + 32'(k) * 32'd4;
        add_beat(32'h3000_0000 | 32'(k), 4'hF);
        write_burst(awid, addr, 1);
        check_value("BID", 32'(awid), 32'(last_bid));
        read_burst(arid, addr, 1, 1'b0);
        check_read(addr, 1, arid);
    end
    end_test();
endtask

task automatic test_write_priority();
    begin_test("write_priority");
    add_beat(32'h0BAD_0BAD, 4'hF);
    write_burst(4'h8, 32'h380, 1);
    add_beat(32'h600D_F00D, 4'hF);
    fork
        write_burst(4'h9, 32'h380, 1);
        read_burst(4'hA, 32'h380, 1, 1'b0);
    join
    check_true("read address accepted before the write response", last_ar_time > last_b_time);
    check_read(32'h380, 1, 4'hA); // Must see the new word
    end_test();
endtask

// File: testbench/axi_sram_tb.sv
`timescale 1ns/1ps

module axi_sram_tb;
    import axi_sram_pkg::*;

    localparam int TIMEOUT = 500; // Cycles allowed for any single wait
    localparam int SEED    = 32'h289cb346;

    localparam logic [1:0] AXI_OKAY = 2'b00; // Normal completion code on B and R

    // Channel selectors for the handshake wait
    localparam int CH_AW = 0;
    localparam int CH_W  = 1;
    localparam int CH_B  = 2;
    localparam int CH_AR = 3;

    logic        ACLK = 1'b0;
    logic        ARESETn;
    logic [3:0]  AWID;
    logic [31:0] AWADDR;
    axi_len_t    AWLEN;
    logic        AWVALID;
    logic        AWREADY;
    logic [31:0] WDATA;
    logic [3:0]  WSTRB;
    logic        WLAST;
    logic        WVALID;
    logic        WREADY;
    logic [3:0]  BID;
    axi_resp_t   BRESP;
    logic        BVALID;
    logic        BREADY;
    logic [3:0]  ARID;
    logic [31:0] ARADDR;
    axi_len_t    ARLEN;
    logic        ARVALID;
    logic        ARREADY;
    logic [3:0]  RID;
    logic [31:0] RDATA;
    axi_resp_t   RRESP;
    logic        RLAST;
    logic        RVALID;
    logic        RREADY;

    logic [31:0] ref_mem [1024]; // Reference copy of the SRAM words

    logic [31:0] wq_data [$];    // Beats for the next write burst
    logic [3:0]  wq_strb [$];
    logic [31:0] rq_data [$];    // Beats collected by the last read burst
    logic [3:0]  rq_id   [$];
    axi_resp_t   rq_resp [$];
    logic        rq_last [$];

    logic [3:0]  last_bid;
    axi_resp_t   last_bresp;
    time         last_b_time;
    time         last_ar_time;

    string cur_test;
    int    errors;
    int    errors_at_start;
    int    tests_run;
    int    tests_failed;

    always #4 ACLK = ~ACLK; // 8 ns period

    axi_sram_top dut_i (
        .ACLK    (ACLK),    .ARESETn (ARESETn),
        .AWID    (AWID),    .AWADDR  (AWADDR),  .AWLEN   (AWLEN),
        .AWVALID (AWVALID), .AWREADY (AWREADY),
        .WDATA   (WDATA),   .WSTRB   (WSTRB),   .WLAST   (WLAST),
        .WVALID  (WVALID),  .WREADY  (WREADY),
        .BID     (BID),     .BRESP   (BRESP),   .BVALID  (BVALID),  .BREADY (BREADY),
        .ARID    (ARID),    .ARADDR  (ARADDR),  .ARLEN   (ARLEN),
        .ARVALID (ARVALID), .ARREADY (ARREADY),
        .RID     (RID),     .RDATA   (RDATA),   .RRESP   (RRESP),
        .RLAST   (RLAST),   .RVALID  (RVALID),  .RREADY  (RREADY)
    );

    task automatic next_cycle();
        @(posedge ACLK);
        #1; // Drive point after the edge
    endtask

    task automatic abort_run(input string what);
        $display("[TIMEOUT] %s: no %s within %0d cycles", cur_test, what, TIMEOUT);
        $display("TEST FAILED");
        $finish;
    endtask

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            $display("[FAIL] %s: %s expected %h actual %h", cur_test, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_true(input string what, input bit ok);
        assert (ok) else begin
            $display("[ERROR] %s: %s", cur_test, what);
            errors++;
        end
    endtask

    task automatic begin_test(input string name);
        cur_test        = name;
        errors_at_start = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors != errors_at_start) begin
            tests_failed++;
            $display("test %s: %0d errors", cur_test, errors - errors_at_start);
        end else begin
            $display("test %s: ok", cur_test);
        end
    endtask

    `include "axi_sram_tb_tasks.svh"

    initial begin
        void'($urandom(SEED));
        ARESETn = 1'b0;
        AWID    = '0;
        AWADDR  = '0;
        AWLEN   = '0;
        AWVALID = 1'b0;
        WDATA   = '0;
        WSTRB   = '0;
        WLAST   = 1'b0;
        WVALID  = 1'b0;
        BREADY  = 1'b0;
        ARID    = '0;
        ARADDR  = '0;
        ARLEN   = '0;
        ARVALID = 1'b0;
        RREADY  = 1'b0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        cur_test     = "reset";
        repeat (4) @(posedge ACLK);
        #1;
        ARESETn = 1'b1;

        test_reset_state();
        test_single_beat();
        test_burst_strobes();
        test_backpressure();
        test_ids();
        test_write_priority();

        $display("Tests run %0d, tests failed %0d, check errors %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: sources.f
+incdir+testbench
verilog/axi_sram_pkg.sv
verilog/axi4_if.sv
verilog/sram_port_if.sv
verilog/axi4_sram.sv
verilog/sram_byte_en.sv
verilog/axi_r_buffer.sv
verilog/axi_sram_top.sv
testbench/axi_sram_tb.sv

// File: Makefile
# Verilator flow for the AXI4 SRAM subsystem
VERILATOR ?= verilator
FILELIST  ?= sources.f
TB_TOP    ?= axi_sram_tb
RTL_TOP   ?= axi_sram_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)

# The log decides the result, the binary status is kept as a fallback
sim: build
	@./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "TEST FAILED" $(LOG); then exit 1; fi; exit $$status

clean:
	rm -rf $(BUILD_DIR) $(LOG)
